// File: design/lf_params.svh
`ifndef LF_PARAMS_SVH
`define LF_PARAMS_SVH

////////////////////
// ADC framing
////////////////////

// Conversion width in bits
`define LF_ADC_BITS 12
// clk cycles per half period of the ADC clock
`define LF_ADC_HALF 2
// ADC clocks per chip-select frame
`define LF_FRAME_CYCLES 16

// Mux addresses of the three reflectance sensors
`define LF_CH_LEFT 3'd5
`define LF_CH_CENTER 3'd6
`define LF_CH_RIGHT 3'd7

////////////////////
// Decision and drive
////////////////////

// Readings strictly above this count as dark
`define LF_WHITE_THRESHOLD 1900
`define LF_DEBOUNCE_SETS 3

`define LF_PWM_PERIOD 100
`define LF_DUTY_FAST 80
`define LF_DUTY_SLOW 40
`define LF_DUTY_BITS 8

`endif

// File: design/lf_pkg.sv
`include "lf_params.svh"

package lf_pkg;

	typedef logic [`LF_ADC_BITS-1:0] adc_sample_t;
	typedef logic [2:0] adc_channel_t;
	typedef logic [`LF_DUTY_BITS-1:0] duty_t;
	typedef logic [3:0] pattern_code_t;

	// One reading per sensor
	typedef struct packed {
		adc_sample_t left;
		adc_sample_t center;
		adc_sample_t right;
	} line_sample_t;

	// High-time counts for one PWM period
	typedef struct packed {
		duty_t rw_f;
		duty_t rw_b;
		duty_t lw_f;
		duty_t lw_b;
	} wheel_cmd_t;

	typedef struct packed {
		logic rw_f;
		logic rw_b;
		logic lw_f;
		logic lw_b;
	} motor_pins_t;

	typedef enum logic [2:0] {
		MV_FORWARD,
		MV_RIGHT,
		MV_LEFT,
		MV_STOP,
		MV_NODE
	} motion_e;

	// Named after the channel converted in the current frame
	typedef enum logic [2:0] {
		RD_IDLE,
		RD_DISCARD,
		RD_LEFT,
		RD_CENTER,
		RD_RIGHT
	} reader_state_e;

endpackage

// File: design/adc_serial_reader.sv
`include "lf_params.svh"

module adc_serial_reader (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 adc_data,
	output logic                 adc_clk,
	output logic                 adc_cs_n,
	output logic                 adc_address,
	output lf_pkg::line_sample_t sample,
	output logic                 sample_valid
);

	localparam int DIV_W = $clog2(`LF_ADC_HALF) + 1;
	localparam int CYC_W = $clog2(`LF_FRAME_CYCLES);
	localparam logic [CYC_W-1:0] LAST_CYCLE = CYC_W'(`LF_FRAME_CYCLES - 1);
	localparam logic [CYC_W-1:0] FIRST_DATA = CYC_W'(`LF_FRAME_CYCLES - `LF_ADC_BITS);

	lf_pkg::reader_state_e state;
	lf_pkg::adc_channel_t next_ch;
	lf_pkg::adc_sample_t shift_q;
	logic [DIV_W-1:0] div_cnt;
	logic [CYC_W-1:0] cyc_cnt;
	logic [CYC_W-1:0] cyc_next;
	logic half_end;
	logic rise;
	logic fall;
	logic frame_end;

	assign half_end = (state != lf_pkg::RD_IDLE) && (div_cnt == DIV_W'(`LF_ADC_HALF - 1));
	assign rise = half_end && !adc_clk;
	assign fall = half_end && adc_clk;
	assign frame_end = fall && (cyc_cnt == LAST_CYCLE);
	assign cyc_next = frame_end ? '0 : cyc_cnt + 1'b1;

	// The address sent now is converted one frame later
	always_comb
	begin
		case (state)
			lf_pkg::RD_LEFT:   next_ch = `LF_CH_CENTER;
			lf_pkg::RD_CENTER: next_ch = `LF_CH_RIGHT;
			default:           next_ch = `LF_CH_LEFT;
		endcase
	end

	////////////////////
	// Clock, frame and address
	////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= lf_pkg::RD_IDLE;
			div_cnt <= '0;
			cyc_cnt <= '0;
			adc_clk <= 1'b0;
			adc_cs_n <= 1'b1;
			adc_address <= 1'b0;
			sample_valid <= 1'b0;
		end
		else
		begin
			sample_valid <= 1'b0;
			if (state == lf_pkg::RD_IDLE)
			begin
				adc_cs_n <= 1'b0;
				state <= lf_pkg::RD_DISCARD;
			end
			else
			begin
				div_cnt <= half_end ? '0 : div_cnt + 1'b1;
				if (half_end)
					adc_clk <= !adc_clk;
				if (fall)
				begin
					cyc_cnt <= cyc_next;
					// MSB first in cycles 2 to 4
					if (cyc_next == CYC_W'(2))
						adc_address <= next_ch[2];
					else if (cyc_next == CYC_W'(3))
						adc_address <= next_ch[1];
					else if (cyc_next == CYC_W'(4))
						adc_address <= next_ch[0];
					else
						adc_address <= 1'b0;
				end
				if (frame_end)
				begin
					case (state)
						lf_pkg::RD_DISCARD: state <= lf_pkg::RD_LEFT;
						lf_pkg::RD_LEFT:    state <= lf_pkg::RD_CENTER;
						lf_pkg::RD_CENTER:  state <= lf_pkg::RD_RIGHT;
						default:            state <= lf_pkg::RD_LEFT;
					endcase
					sample_valid <= (state == lf_pkg::RD_RIGHT);
				end
			end
		end
	end

	////////////////////
	// Data capture
	////////////////////

	always_ff @(posedge clk)
	begin
		if (rise && cyc_cnt >= FIRST_DATA)
			shift_q <= {shift_q[`LF_ADC_BITS-2:0], adc_data};
		if (frame_end)
		begin
			case (state)
				lf_pkg::RD_LEFT:   sample.left <= shift_q;
				lf_pkg::RD_CENTER: sample.center <= shift_q;
				lf_pkg::RD_RIGHT:  sample.right <= shift_q;
				default:           sample <= sample;
			endcase
		end
	end

endmodule

// File: design/line_decision.sv
`include "lf_params.svh"

module line_decision (
	input  logic                  clk,
	input  logic                  rst_n,
	input  lf_pkg::line_sample_t  sample,
	input  logic                  sample_valid,
	input  logic                  done,
	output lf_pkg::wheel_cmd_t    cmd,
	output logic                  cmd_valid,
	output logic                  led_l,
	output logic                  led_m,
	output logic                  led_r,
	output lf_pkg::pattern_code_t digits
);

	localparam lf_pkg::adc_sample_t THRESHOLD = `LF_WHITE_THRESHOLD;
	localparam lf_pkg::duty_t DUTY_FAST = `LF_DUTY_FAST;
	localparam lf_pkg::duty_t DUTY_SLOW = `LF_DUTY_SLOW;
	localparam int REP_W = $clog2(`LF_DEBOUNCE_SETS + 1);

	// Left, centre, right with 1 for dark
	logic [2:0] pattern;
	logic [2:0] last_pattern;
	logic [REP_W-1:0] rep_cnt;
	logic [REP_W-1:0] rep_next;
	logic busy;
	logic accept;
	logic issue;
	lf_pkg::motion_e motion;
	lf_pkg::wheel_cmd_t duties;

	assign pattern = {sample.left > THRESHOLD, sample.center > THRESHOLD,
		sample.right > THRESHOLD};
	assign accept = sample_valid && !busy;
	assign rep_next = (rep_cnt != '0 && pattern == last_pattern) ? rep_cnt + 1'b1 : REP_W'(1);
	assign issue = accept && (rep_next == REP_W'(`LF_DEBOUNCE_SETS));

	always_comb
	begin
		case (pattern)
			3'b000, 3'b101: motion = lf_pkg::MV_STOP;
			3'b001, 3'b011: motion = lf_pkg::MV_RIGHT;
			3'b010:         motion = lf_pkg::MV_FORWARD;
			3'b100, 3'b110: motion = lf_pkg::MV_LEFT;
			default:        motion = lf_pkg::MV_NODE;
		endcase
	end

	always_comb
	begin
		duties = '0;
		case (motion)
			lf_pkg::MV_FORWARD:
			begin
				duties.rw_f = DUTY_FAST;
				duties.lw_f = DUTY_FAST;
			end
			// Pivot with the right wheel backing off
			lf_pkg::MV_RIGHT:
			begin
				duties.rw_b = DUTY_SLOW;
				duties.lw_f = DUTY_FAST;
			end
			lf_pkg::MV_LEFT:
			begin
				duties.rw_f = DUTY_FAST;
				duties.lw_b = DUTY_SLOW;
			end
			default:
				duties = '0;
		endcase
	end

	////////////////////
	// LEDs and debounce
	////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			led_l <= 1'b0;
			led_m <= 1'b0;
			led_r <= 1'b0;
			last_pattern <= '0;
			rep_cnt <= '0;
			busy <= 1'b0;
			cmd_valid <= 1'b0;
			digits <= '0;
		end
		else
		begin
			cmd_valid <= 1'b0;
			if (sample_valid)
			begin
				// Lit over white
				led_l <= !pattern[2];
				led_m <= !pattern[1];
				led_r <= !pattern[0];
			end
			if (accept)
			begin
				last_pattern <= pattern;
				rep_cnt <= issue ? '0 : rep_next;
			end
			if (issue)
			begin
				cmd_valid <= 1'b1;
				busy <= 1'b1;
				// codes 1 to 8 follow the pattern value
				digits <= {1'b0, pattern} + 4'd1;
			end
			else if (done)
			begin
				busy <= 1'b0;
				digits <= '0;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (issue)
			cmd <= duties;
	end

endmodule

// File: design/wheel_pwm.sv
`include "lf_params.svh"

module wheel_pwm (
	input  logic                clk,
	input  logic                rst_n,
	input  lf_pkg::wheel_cmd_t  cmd,
	input  logic                cmd_valid,
	output logic                done,
	output lf_pkg::motor_pins_t pins
);

	localparam int CNT_W = $clog2(`LF_PWM_PERIOD);
	localparam logic [CNT_W-1:0] LAST = CNT_W'(`LF_PWM_PERIOD - 1);

	lf_pkg::wheel_cmd_t cmd_q;
	logic [CNT_W-1:0] cnt;
	logic running;

	// High for the first duty cycles of the period
	function automatic logic pin_high(input lf_pkg::duty_t duty, input logic [CNT_W-1:0] count);
		return lf_pkg::duty_t'(count) < duty;
	endfunction

	assign done = running && (cnt == LAST);

	assign pins.rw_f = running && pin_high(cmd_q.rw_f, cnt);
	assign pins.rw_b = running && pin_high(cmd_q.rw_b, cnt);
	assign pins.lw_f = running && pin_high(cmd_q.lw_f, cnt);
	assign pins.lw_b = running && pin_high(cmd_q.lw_b, cnt);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			running <= 1'b0;
			cnt <= '0;
		end
		else if (running)
		begin
			if (done)
			begin
				running <= 1'b0;
				cnt <= '0;
			end
			else
				cnt <= cnt + 1'b1;
		end
		else if (cmd_valid)
		begin
			running <= 1'b1;
			cnt <= '0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (cmd_valid && !running)
			cmd_q <= cmd;
	end

endmodule

// File: design/line_follower_top.sv
module line_follower_top (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  adc_data,
	output logic                  adc_clk,
	output logic                  adc_cs_n,
	output logic                  adc_address,
	output logic                  rw_f,
	output logic                  rw_b,
	output logic                  lw_f,
	output logic                  lw_b,
	output logic                  led_l,
	output logic                  led_m,
	output logic                  led_r,
	output lf_pkg::pattern_code_t digits
);

	lf_pkg::line_sample_t sample;
	logic sample_valid;
	lf_pkg::wheel_cmd_t cmd;
	logic cmd_valid;
	logic done;
	lf_pkg::motor_pins_t pins;

	adc_serial_reader u_adc_serial_reader (
		.clk          (clk),
		.rst_n        (rst_n),
		.adc_data     (adc_data),
		.adc_clk      (adc_clk),
		.adc_cs_n     (adc_cs_n),
		.adc_address  (adc_address),
		.sample       (sample),
		.sample_valid (sample_valid)
	);

	line_decision u_line_decision (
		.clk          (clk),
		.rst_n        (rst_n),
		.sample       (sample),
		.sample_valid (sample_valid),
		.done         (done),
		.cmd          (cmd),
		.cmd_valid    (cmd_valid),
		.led_l        (led_l),
		.led_m        (led_m),
		.led_r        (led_r),
		.digits       (digits)
	);

	wheel_pwm u_wheel_pwm (
		.clk       (clk),
		.rst_n     (rst_n),
		.cmd       (cmd),
		.cmd_valid (cmd_valid),
		.done      (done),
		.pins      (pins)
	);

	assign rw_f = pins.rw_f;
	assign rw_b = pins.rw_b;
	assign lw_f = pins.lw_f;
	assign lw_b = pins.lw_b;

endmodule

// File: dv/line_follower_assert.sv
module line_follower_assert (
	input logic clk,
	input logic rst_n,
	input logic rw_f,
	input logic rw_b,
	input logic lw_f,
	input logic lw_b,
	input logic cmd_valid,
	input logic done,
	input logic adc_cs_n
);
	timeunit 1ns;
	timeprecision 1ps;

	// Set between a command and its done pulse
	logic outstanding;
	int fail_count = 0;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			outstanding <= 1'b0;
		else if (cmd_valid)
			outstanding <= 1'b1;
		else if (done)
			outstanding <= 1'b0;
	end

	wheel_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(rw_f && rw_b) && !(lw_f && lw_b))
		else
		begin
			fail_count++;
			$error("front and back pins of one wheel are high together");
		end

	single_command: assert property (@(posedge clk) disable iff (!rst_n)
		!(cmd_valid && outstanding))
		else
		begin
			fail_count++;
			$error("new command issued before done");
		end

	cs_held_low: assert property (@(posedge clk) disable iff (!rst_n)
		!adc_cs_n |=> !adc_cs_n)
		else
		begin
			fail_count++;
			$error("ADC chip select released after framing started");
		end

endmodule

// File: dv/line_follower_tb.sv
`include "lf_params.svh"

module line_follower_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_ENTRIES = 9;
	localparam int SETS_PER_ENTRY = 6;
	localparam int SET_CYCLES = 3 * `LF_FRAME_CYCLES * 2 * `LF_ADC_HALF;
	localparam int TIMEOUT_CYCLES = NUM_ENTRIES * SETS_PER_ENTRY * SET_CYCLES * 2;
	localparam lf_pkg::duty_t FAST = lf_pkg::duty_t'(`LF_DUTY_FAST);
	localparam lf_pkg::duty_t SLOW = lf_pkg::duty_t'(`LF_DUTY_SLOW);

	// Readings, alternate flag, jitter flag, expected code and duties
	typedef struct packed {
		lf_pkg::adc_sample_t left;
		lf_pkg::adc_sample_t center;
		lf_pkg::adc_sample_t right;
		logic toggle;
		logic jitter;
		lf_pkg::pattern_code_t code;
		lf_pkg::wheel_cmd_t duties;
	} stim_t;

	logic clk;
	logic rst_n;
	logic adc_data;
	logic adc_clk;
	logic adc_cs_n;
	logic adc_address;
	logic rw_f;
	logic rw_b;
	logic lw_f;
	logic lw_b;
	logic led_l;
	logic led_m;
	logic led_r;
	lf_pkg::pattern_code_t digits;

	stim_t stim [NUM_ENTRIES];
	int seed = 30297;
	int value_errors = 0;
	int other_errors = 0;
	int assert_errors = 0;
	int cycles = 0;
	lf_pkg::adc_sample_t cur_l, cur_c, cur_r;
	lf_pkg::adc_sample_t conv_l, conv_c, conv_r, conv;
	int cyc = 0;
	logic [2:0] addr_shift, addr_next;
	logic [2:0] addr_cur = 3'd0;
	int addr_count = 0;
	int set_entry = 0;
	logic in_move = 1'b0;
	int mv_entry;
	lf_pkg::pattern_code_t mv_code;
	int high_cnt [4];
	int moves [NUM_ENTRIES];

	line_follower_top u_line_follower_top (.*);

	bind line_follower_top line_follower_assert u_line_follower_assert (
		.clk       (clk),
		.rst_n     (rst_n),
		.rw_f      (rw_f),
		.rw_b      (rw_b),
		.lw_f      (lw_f),
		.lw_b      (lw_b),
		.cmd_valid (cmd_valid),
		.done      (done),
		.adc_cs_n  (adc_cs_n)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles > TIMEOUT_CYCLES)
		begin
			$display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	task automatic report_value(input string name, input int got, input int exp);
		value_errors++;
		$display("ERROR t=%0t %s got %0d expected %0d", $time, name, got, exp);
	endtask

	function automatic stim_t make_row(input int l, input int c, input int r, input logic tg,
		input logic jt, input int code, input lf_pkg::duty_t rwf, input lf_pkg::duty_t rwb,
		input lf_pkg::duty_t lwf, input lf_pkg::duty_t lwb);
		stim_t row;
		row.left = lf_pkg::adc_sample_t'(l);
		row.center = lf_pkg::adc_sample_t'(c);
		row.right = lf_pkg::adc_sample_t'(r);
		row.toggle = tg;
		row.jitter = jt;
		row.code = lf_pkg::pattern_code_t'(code);
		row.duties = '{rw_f: rwf, rw_b: rwb, lw_f: lwf, lw_b: lwb};
		return row;
	endfunction

	task automatic fill_table();
		stim[0] = make_row(500, 600, 700, 1'b0, 1'b0, 1, 0, 0, 0, 0);
		// Exact threshold on the centre, one above on the right
		stim[1] = make_row(800, 1900, 1901, 1'b0, 1'b0, 2, 0, SLOW, FAST, 0);
		stim[2] = make_row(1000, 3000, 1200, 1'b0, 1'b0, 3, FAST, 0, FAST, 0);
		stim[3] = make_row(1700, 2500, 2600, 1'b0, 1'b1, 4, 0, SLOW, FAST, 0);
		// Left and right swap every set, so no movement may start
		stim[4] = make_row(3000, 500, 500, 1'b1, 1'b0, 0, 0, 0, 0, 0);
		stim[5] = make_row(2800, 1000, 900, 1'b0, 1'b0, 5, FAST, 0, 0, SLOW);
		stim[6] = make_row(1901, 1850, 2000, 1'b0, 1'b1, 6, 0, 0, 0, 0);
		stim[7] = make_row(2200, 2300, 1800, 1'b0, 1'b0, 7, FAST, 0, 0, SLOW);
		stim[8] = make_row(4000, 3900, 3800, 1'b0, 1'b0, 8, 0, 0, 0, 0);
	endtask

	// Random offset that moves a reading away from the threshold
	function automatic lf_pkg::adc_sample_t jittered(input lf_pkg::adc_sample_t base);
		int rnd;
		rnd = $random(seed) & 63;
		if (base > `LF_WHITE_THRESHOLD)
			return lf_pkg::adc_sample_t'(base + rnd);
		return lf_pkg::adc_sample_t'(base - rnd);
	endfunction

	task automatic apply_readings(input int e, input int s);
		lf_pkg::adc_sample_t l, c, r;
		l = stim[e].left;
		c = stim[e].center;
		r = stim[e].right;
		if (stim[e].toggle && s % 2 == 1)
		begin
			l = stim[e].right;
			r = stim[e].left;
		end
		if (stim[e].jitter)
		begin
			l = jittered(l);
			c = jittered(c);
			r = jittered(r);
		end
		cur_l = l;
		cur_c = c;
		cur_r = r;
	endtask

	////////////////////
	// ADC model
	////////////////////

	always @(negedge adc_clk)
	begin
		if (rst_n === 1'b1)
		begin
			if (cyc == `LF_FRAME_CYCLES - 1)
			begin
				cyc = 0;
				addr_cur = addr_next;
			end
			else
				cyc = cyc + 1;
			if (cyc == `LF_FRAME_CYCLES - `LF_ADC_BITS)
			begin
				case (addr_cur)
					`LF_CH_LEFT: conv = cur_l;
					`LF_CH_CENTER: conv = cur_c;
					`LF_CH_RIGHT: conv = cur_r;
					default: conv = '0;
				endcase
				if (addr_cur == `LF_CH_LEFT)
					conv_l = conv;
				else if (addr_cur == `LF_CH_CENTER)
					conv_c = conv;
				else if (addr_cur == `LF_CH_RIGHT)
					conv_r = conv;
			end
			if (cyc >= `LF_FRAME_CYCLES - `LF_ADC_BITS)
				adc_data <= conv[`LF_FRAME_CYCLES - 1 - cyc];
		end
	end

	always @(posedge adc_clk)
	begin
		if (cyc >= 2 && cyc <= 4)
			addr_shift = {addr_shift[1:0], adc_address};
		if (cyc == 4)
		begin
			addr_next = addr_shift;
			if (addr_shift != 3'(5 + addr_count % 3))
			begin
				other_errors++;
				$display("Address order is wrong at %0t: channel %0d seen where %0d was due",
					$time, addr_shift, 5 + addr_count % 3);
			end
			addr_count++;
		end
	end

	////////////////////
	// Movement monitor
	////////////////////

	task automatic finish_movement();
		lf_pkg::wheel_cmd_t d;
		d = stim[mv_entry].duties;
		moves[mv_entry]++;
		if (stim[mv_entry].toggle)
		begin
			other_errors++;
			$display("A movement started although the pattern changed on every set (%0t)", $time);
		end
		if (mv_code != stim[mv_entry].code)
			report_value("digits", mv_code, stim[mv_entry].code);
		if (high_cnt[0] != d.rw_f)
			report_value("rw_f high cycles", high_cnt[0], d.rw_f);
		if (high_cnt[1] != d.rw_b)
			report_value("rw_b high cycles", high_cnt[1], d.rw_b);
		if (high_cnt[2] != d.lw_f)
			report_value("lw_f high cycles", high_cnt[2], d.lw_f);
		if (high_cnt[3] != d.lw_b)
			report_value("lw_b high cycles", high_cnt[3], d.lw_b);
	endtask

	always @(negedge clk)
	begin
		if (rst_n === 1'b1)
		begin
			if (digits != 4'd0)
			begin
				if (!in_move)
				begin
					in_move = 1'b1;
					mv_entry = set_entry;
					mv_code = digits;
					high_cnt = '{0, 0, 0, 0};
				end
				else if (digits != mv_code)
					report_value("digits", digits, mv_code);
				high_cnt[0] += int'(rw_f);
				high_cnt[1] += int'(rw_b);
				high_cnt[2] += int'(lw_f);
				high_cnt[3] += int'(lw_b);
			end
			else
			begin
				if (in_move)
				begin
					finish_movement();
					in_move = 1'b0;
				end
				if (rw_f || rw_b || lw_f || lw_b)
				begin
					other_errors++;
					$display("A motor pin is high with no movement running (%0t)", $time);
				end
			end
		end
	end

	////////////////////
	// Checks and main flow
	////////////////////

	task automatic check_reset();
		if ({rw_f, rw_b, lw_f, lw_b} !== 4'b0000)
			report_value("motor pins", {rw_f, rw_b, lw_f, lw_b}, 0);
		if (digits !== 4'd0)
			report_value("digits", digits, 0);
		if ({led_l, led_m, led_r} !== 3'b000)
			report_value("leds", {led_l, led_m, led_r}, 0);
		if (adc_cs_n !== 1'b1)
			report_value("adc_cs_n", adc_cs_n, 1);
		if (adc_clk !== 1'b0)
			report_value("adc_clk", adc_clk, 0);
	endtask

	task automatic wait_set();
		do
			@(posedge clk);
		while (u_line_follower_top.sample_valid !== 1'b1);
	endtask

	task automatic check_leds();
		@(negedge clk);
		if (led_l !== (conv_l <= `LF_WHITE_THRESHOLD))
			report_value("led_l", led_l, conv_l <= `LF_WHITE_THRESHOLD);
		if (led_m !== (conv_c <= `LF_WHITE_THRESHOLD))
			report_value("led_m", led_m, conv_c <= `LF_WHITE_THRESHOLD);
		if (led_r !== (conv_r <= `LF_WHITE_THRESHOLD))
			report_value("led_r", led_r, conv_r <= `LF_WHITE_THRESHOLD);
	endtask

	initial
	begin
		rst_n = 1'b0;
		adc_data = 1'b0;
		moves = '{default: 0};
		fill_table();
		apply_readings(0, 0);
		for (int i = 0; i < 16; i++)
		begin
			@(posedge clk);
			if (i == 15)
				rst_n <= 1'b1;
			if (i >= 2)
			begin
				@(negedge clk);
				check_reset();
			end
		end
		for (int e = 0; e < NUM_ENTRIES; e++)
		begin
			for (int s = 0; s < SETS_PER_ENTRY; s++)
			begin
				wait_set();
				set_entry = e;
				check_leds();
				if (s < SETS_PER_ENTRY - 1)
					apply_readings(e, s + 1);
				else if (e < NUM_ENTRIES - 1)
					apply_readings(e + 1, 0);
			end
		end
		// Let the last movement run out
		repeat (2) @(negedge clk);
		while (in_move)
			@(negedge clk);
		for (int e = 0; e < NUM_ENTRIES; e++)
		begin
			if (moves[e] != (stim[e].toggle ? 0 : 2))
			begin
				other_errors++;
				$display("Entry %0d produced %0d movements instead of %0d", e, moves[e],
					stim[e].toggle ? 0 : 2);
			end
		end
		assert_errors = u_line_follower_top.u_line_follower_assert.fail_count;
		$display("Run complete: %0d value errors, %0d other errors, %0d assertion failures",
			value_errors, other_errors, assert_errors);
		if (value_errors == 0 && other_errors == 0 && assert_errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// File: build.f
+incdir+design
design/lf_pkg.sv
design/adc_serial_reader.sv
design/line_decision.sv
design/wheel_pwm.sv
design/line_follower_top.sv
dv/line_follower_assert.sv
dv/line_follower_tb.sv

// File: Makefile
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert -j 0
TOP      ?= line_follower_tb
FILELIST ?= build.f
OBJ_DIR  ?= obj_dir
LOG      ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "\*\*\* TEST FAILED \*\*\*" $(LOG); then exit 1; fi
	@grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
